/* hdl/ddr_geom_pkg.sv */
`default_nettype none

package ddr_geom_pkg;

	localparam int bg_w     = 1;
	localparam int ba_w     = 2;
	localparam int row_w    = 3;
	localparam int col_w    = 3;
	localparam int num_cols = 8;  // row buffer depth
	localparam int data_w   = 16;
	localparam int addr_w   = 17;

	typedef logic [bg_w+ba_w-1:0] bank_t;  // {bank group, bank}
	typedef logic [row_w-1:0]     row_t;
	typedef logic [col_w-1:0]     col_t;
	typedef logic [data_w-1:0]    data_t;

	// address pins carry a row on ACTIVATE and the command bits otherwise
	typedef union packed {
		struct packed {
			logic [addr_w-row_w-1:0] a16_3;
			row_t                    row;
		} row_v;
		struct packed {
			logic           ras_n;  // a16
			logic           cas_n;  // a15
			logic           we_n;   // a14
			logic           a13;
			logic           bc_n;   // burst chop, ignored
			logic           a11;
			logic           ap;     // auto-precharge
			logic [9-col_w:0] a9_3;
			col_t           col;
		} col_v;
	} addr_word_u;

endpackage

`default_nettype wire

/* hdl/ddr_cmd_pkg.sv */
`default_nettype none

package ddr_cmd_pkg;

	typedef enum logic [2:0] {
		cmd_nop,
		cmd_activate,
		cmd_read,
		cmd_write,
		cmd_precharge,
		cmd_refresh
	} cmd_e;

	// {ras_n, cas_n, we_n} with act_n high
	localparam logic [2:0] rcw_read      = 3'b101;
	localparam logic [2:0] rcw_write     = 3'b100;
	localparam logic [2:0] rcw_precharge = 3'b010;
	localparam logic [2:0] rcw_refresh   = 3'b001;

endpackage

`default_nettype wire

/* hdl/ddr_cmd_if.sv */
`default_nettype none
`timescale 1ns/1ps

// one decoded command, valid for a single cycle
interface ddr_cmd_if;

	logic                cmd_valid;
	ddr_cmd_pkg::cmd_e   cmd;
	ddr_geom_pkg::bank_t bank;
	ddr_geom_pkg::row_t  row;       // meaningful on activate only
	ddr_geom_pkg::col_t  col;
	logic                auto_pre;
	ddr_geom_pkg::data_t wdata;

	modport issue (
		output cmd_valid,
		output cmd,
		output bank,
		output row,
		output col,
		output auto_pre,
		output wdata
	);

	modport accept (
		input cmd_valid,
		input cmd,
		input bank,
		input row,
		input col,
		input auto_pre,
		input wdata
	);

endinterface

`default_nettype wire

/* hdl/cmd_decode.sv */
`default_nettype none
`timescale 1ns/1ps

module cmd_decode (
	input  logic                              ck_t,
	input  logic                              rst_n,
	input  logic                              cs_n,
	input  logic                              act_n,
	input  logic [ddr_geom_pkg::bg_w-1:0]     bg,
	input  logic [ddr_geom_pkg::ba_w-1:0]     ba,
	input  ddr_geom_pkg::addr_word_u          addr,
	input  ddr_geom_pkg::data_t               data_in,
	ddr_cmd_if.issue                          cmd
);

	ddr_cmd_pkg::cmd_e dec_cmd;

	always_comb
	begin
		dec_cmd = ddr_cmd_pkg::cmd_nop;
		if (!cs_n)
		begin
			if (!act_n)
				dec_cmd = ddr_cmd_pkg::cmd_activate;
			else
				case ({addr.col_v.ras_n, addr.col_v.cas_n, addr.col_v.we_n})
					ddr_cmd_pkg::rcw_write:     dec_cmd = ddr_cmd_pkg::cmd_write;
					ddr_cmd_pkg::rcw_read:      dec_cmd = ddr_cmd_pkg::cmd_read;
					ddr_cmd_pkg::rcw_precharge: dec_cmd = ddr_cmd_pkg::cmd_precharge;
					ddr_cmd_pkg::rcw_refresh:   dec_cmd = ddr_cmd_pkg::cmd_refresh;
					default:                    dec_cmd = ddr_cmd_pkg::cmd_nop;
				endcase
		end
	end

	always_ff @(posedge ck_t)
	begin
		if (!rst_n)
			cmd.cmd_valid <= 1'b0;
		else
			cmd.cmd_valid <= (dec_cmd != ddr_cmd_pkg::cmd_nop);  // deselect and nop drop out
	end

	// payload, only meaningful alongside cmd_valid
	always_ff @(posedge ck_t)
	begin
		cmd.cmd   <= dec_cmd;
		cmd.bank  <= {bg, ba};
		cmd.wdata <= data_in;
		if (!act_n)
			cmd.row <= addr.row_v.row;
		else
		begin
			cmd.col      <= addr.col_v.col;
			cmd.auto_pre <= addr.col_v.ap;
		end
	end

endmodule

`default_nettype wire

/* hdl/refresh_timer.sv */
`default_nettype none
`timescale 1ns/1ps

module refresh_timer #(
	parameter int refresh_interval = 200,
	parameter int refresh_cycles   = 12
) (
	input  logic ck_t,
	input  logic rst_n,
	input  logic refresh_start,
	output logic refresh_due,
	output logic refresh_active
);

	localparam int int_w = $clog2(refresh_interval + 1);
	localparam int act_w = $clog2(refresh_cycles + 1);

	logic [int_w-1:0] interval_cnt;
	logic [act_w-1:0] active_cnt;   // cycles left in the current refresh

	always_ff @(posedge ck_t)
	begin
		if (!rst_n)
		begin
			interval_cnt   <= '0;
			active_cnt     <= '0;
			refresh_due    <= 1'b0;
			refresh_active <= 1'b0;
		end
		else if (refresh_start)
		begin
			// explicit or periodic, both restart the schedule
			interval_cnt   <= '0;
			refresh_due    <= 1'b0;
			refresh_active <= 1'b1;
			active_cnt     <= act_w'(refresh_cycles - 1);
		end
		else
		begin
			if (refresh_active)
			begin
				if (active_cnt == '0)
					refresh_active <= 1'b0;
				else
					active_cnt <= active_cnt - 1'b1;
			end
			if (interval_cnt == int_w'(refresh_interval - 1))
				refresh_due <= 1'b1;  // held until the engine starts one
			else
				interval_cnt <= interval_cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* hdl/bank_engine.sv */
`default_nettype none
`timescale 1ns/1ps

module bank_engine (
	input  logic                ck_t,
	input  logic                rst_n,
	ddr_cmd_if.accept           cmd,
	input  logic                refresh_due,
	input  logic                refresh_active,
	output logic                refresh_start,
	output logic                busy,
	output logic                rd_issue,
	output ddr_geom_pkg::data_t rd_word
);

	localparam int num_banks = 2 ** (ddr_geom_pkg::bg_w + ddr_geom_pkg::ba_w);
	localparam int num_rows  = 2 ** ddr_geom_pkg::row_w;
	localparam ddr_geom_pkg::col_t last_col = ddr_geom_pkg::col_t'(ddr_geom_pkg::num_cols - 1);

	localparam logic [1:0] st_idle    = 2'd0;
	localparam logic [1:0] st_load    = 2'd1;  // bank row into row buffer
	localparam logic [1:0] st_wb      = 2'd2;  // row buffer back to bank
	localparam logic [1:0] st_refresh = 2'd3;

	ddr_geom_pkg::data_t mem [num_banks][num_rows][ddr_geom_pkg::num_cols];
	ddr_geom_pkg::data_t row_buf [ddr_geom_pkg::num_cols];  // sense amps

	logic [1:0]          state;
	logic [1:0]          after_wb;   // where a write-back goes next
	logic                row_open;
	ddr_geom_pkg::col_t  word_cnt;
	ddr_geom_pkg::bank_t open_bank;
	ddr_geom_pkg::row_t  open_row;
	ddr_geom_pkg::bank_t load_bank;
	ddr_geom_pkg::row_t  load_row;

	logic take;
	logic hit;
	logic do_act;
	logic do_write;
	logic do_read;
	logic do_refresh;
	logic do_close;

	// a pending periodic refresh wins over the command in the same cycle
	assign take       = (state == st_idle) && !refresh_due && cmd.cmd_valid;
	assign hit        = row_open && (cmd.bank == open_bank);
	assign do_act     = take && (cmd.cmd == ddr_cmd_pkg::cmd_activate);
	assign do_write   = take && (cmd.cmd == ddr_cmd_pkg::cmd_write) && hit;
	assign do_read    = take && (cmd.cmd == ddr_cmd_pkg::cmd_read) && hit;
	assign do_refresh = (state == st_idle) &&
		(refresh_due || (take && cmd.cmd == ddr_cmd_pkg::cmd_refresh));
	assign do_close   = (take && cmd.cmd == ddr_cmd_pkg::cmd_precharge && row_open) ||
		((do_write || do_read) && cmd.auto_pre);

	assign busy = (state != st_idle);

	always_ff @(posedge ck_t)
	begin
		if (!rst_n)
		begin
			state         <= st_idle;
			after_wb      <= st_idle;
			row_open      <= 1'b0;
			word_cnt      <= '0;
			refresh_start <= 1'b0;
			rd_issue      <= 1'b0;
		end
		else
		begin
			refresh_start <= 1'b0;
			rd_issue      <= do_read;
			case (state)
				st_idle:
				begin
					if (do_refresh)
					begin
						if (row_open)
						begin
							state    <= st_wb;  // close the row first
							after_wb <= st_refresh;
						end
						else
						begin
							state         <= st_refresh;
							refresh_start <= 1'b1;
						end
					end
					else if (do_act)
					begin
						state    <= row_open ? st_wb : st_load;  // implicit precharge
						after_wb <= st_load;
					end
					else if (do_close)
					begin
						state    <= st_wb;
						after_wb <= st_idle;
					end
				end
				st_load:
				begin
					word_cnt <= word_cnt + 1'b1;  // wraps back to 0 on the last word
					if (word_cnt == last_col)
					begin
						state    <= st_idle;
						row_open <= 1'b1;
					end
				end
				st_wb:
				begin
					word_cnt <= word_cnt + 1'b1;
					if (word_cnt == last_col)
					begin
						state         <= after_wb;
						row_open      <= 1'b0;
						refresh_start <= (after_wb == st_refresh);
					end
				end
				default:
				begin
					// start pulse still high in the first refresh cycle
					if (!refresh_start && !refresh_active)
						state <= st_idle;
				end
			endcase
		end
	end

	always_ff @(posedge ck_t)
	begin
		if (do_act)
		begin
			load_bank <= cmd.bank;
			load_row  <= cmd.row;
		end
		if (state == st_load)
		begin
			row_buf[word_cnt] <= mem[load_bank][load_row][word_cnt];
			if (word_cnt == last_col)
			begin
				open_bank <= load_bank;
				open_row  <= load_row;
			end
		end
		if (state == st_wb)
			mem[open_bank][open_row][word_cnt] <= row_buf[word_cnt];
		if (do_write)
			row_buf[cmd.col] <= cmd.wdata;
		if (do_read)
			rd_word <= row_buf[cmd.col];
	end

endmodule

`default_nettype wire

/* hdl/read_return.sv */
`default_nettype none
`timescale 1ns/1ps

module read_return #(
	parameter int read_latency = 4
) (
	input  logic                ck_t,
	input  logic                rst_n,
	input  logic                rd_issue,
	input  ddr_geom_pkg::data_t rd_word,
	output logic                rd_valid,
	output ddr_geom_pkg::data_t rd_data
);

	logic [read_latency-1:0] vld_pipe;
	ddr_geom_pkg::data_t     data_pipe [read_latency];

	always_ff @(posedge ck_t)
	begin
		if (!rst_n)
			vld_pipe <= '0;
		else
		begin
			vld_pipe[0] <= rd_issue;
			for (int i = 1; i < read_latency; i++)
				vld_pipe[i] <= vld_pipe[i-1];
		end
	end

	// words ride alongside their valid bit
	always_ff @(posedge ck_t)
	begin
		data_pipe[0] <= rd_word;
		for (int i = 1; i < read_latency; i++)
			data_pipe[i] <= data_pipe[i-1];
	end

	assign rd_valid = vld_pipe[read_latency-1];
	assign rd_data  = data_pipe[read_latency-1];

endmodule

`default_nettype wire

/* hdl/ddr_bank_top.sv */
`default_nettype none
`timescale 1ns/1ps

module ddr_bank_top #(
	parameter int read_latency     = 4,
	parameter int refresh_interval = 200,
	parameter int refresh_cycles   = 12
) (
	input  logic                          ck_t,
	input  logic                          rst_n,
	input  logic                          cs_n,
	input  logic                          act_n,
	input  logic [ddr_geom_pkg::bg_w-1:0] bg,
	input  logic [ddr_geom_pkg::ba_w-1:0] ba,
	input  logic [ddr_geom_pkg::addr_w-1:0] addr,
	input  logic [ddr_geom_pkg::data_w-1:0] data_in,
	output logic                          busy,
	output logic                          rd_valid,
	output logic [ddr_geom_pkg::data_w-1:0] rd_data
);

	logic                refresh_due;
	logic                refresh_active;
	logic                refresh_start;
	logic                rd_issue;
	ddr_geom_pkg::data_t rd_word;

	ddr_cmd_if cmd_bus ();

	cmd_decode u_decode (
		.ck_t    (ck_t),
		.rst_n   (rst_n),
		.cs_n    (cs_n),
		.act_n   (act_n),
		.bg      (bg),
		.ba      (ba),
		.addr    (addr),
		.data_in (data_in),
		.cmd     (cmd_bus.issue)
	);

	refresh_timer #(
		.refresh_interval (refresh_interval),
		.refresh_cycles   (refresh_cycles)
	) u_refresh (
		.ck_t           (ck_t),
		.rst_n          (rst_n),
		.refresh_start  (refresh_start),
		.refresh_due    (refresh_due),
		.refresh_active (refresh_active)
	);

	bank_engine u_engine (
		.ck_t           (ck_t),
		.rst_n          (rst_n),
		.cmd            (cmd_bus.accept),
		.refresh_due    (refresh_due),
		.refresh_active (refresh_active),
		.refresh_start  (refresh_start),
		.busy           (busy),
		.rd_issue       (rd_issue),
		.rd_word        (rd_word)
	);

	read_return #(
		.read_latency (read_latency)  // CAS latency
	) u_return (
		.ck_t     (ck_t),
		.rst_n    (rst_n),
		.rd_issue (rd_issue),
		.rd_word  (rd_word),
		.rd_valid (rd_valid),
		.rd_data  (rd_data)
	);

endmodule

`default_nettype wire

/* tb/tb_ddr_bank.sv */
`default_nettype none
`timescale 1ns/1ps

module tb_ddr_bank;

	localparam int max_ops      = 64;
	localparam int fields       = 8;    // hex words per line of the data file
	localparam int idle_limit   = 100;  // cycles
	localparam int drain_limit  = 50;
	localparam int read_latency = 4;

	// {ras_n, cas_n, we_n} with act_n high
	localparam logic [2:0] rcw_write     = 3'b100;
	localparam logic [2:0] rcw_read      = 3'b101;
	localparam logic [2:0] rcw_precharge = 3'b010;
	localparam logic [2:0] rcw_refresh   = 3'b001;

	logic        ck_t;
	logic        rst_n;
	logic        cs_n;
	logic        act_n;
	logic        bg;
	logic [1:0]  ba;
	logic [16:0] addr;
	logic [15:0] data_in;
	logic        busy;
	logic        rd_valid;
	logic [15:0] rd_data;

	logic [15:0] stim [0:max_ops*fields-1];
	logic [15:0] model [0:7][0:7][0:7];  // bank, row, col
	logic [15:0] exp_q [$];              // outstanding reads in issue order
	string       name_q [$];
	int          edge_q [$];             // rising edge that sampled each read
	int          cycle;                  // rising edges so far
	int          errors;
	int          checks;
	integer      seed;

	ddr_bank_top UUT (
		.ck_t     (ck_t),
		.rst_n    (rst_n),
		.cs_n     (cs_n),
		.act_n    (act_n),
		.bg       (bg),
		.ba       (ba),
		.addr     (addr),
		.data_in  (data_in),
		.busy     (busy),
		.rd_valid (rd_valid),
		.rd_data  (rd_data)
	);

	initial
	begin
		ck_t = 1'b0;
		forever #4 ck_t = ~ck_t;
	end

	always @(posedge ck_t)
		cycle <= cycle + 1;

	task automatic check(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
	begin
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
		end
	end
	endtask

	// drive one command for a single cycle, returns at the next falling edge
	task automatic issue(input logic is_act, input logic [2:0] rcw, input logic [2:0] bank,
		input logic [2:0] row, input logic [2:0] col, input logic ap,
		input logic [15:0] data);
	begin
		cs_n     = 1'b0;
		act_n    = !is_act;
		{bg, ba} = bank;
		addr     = '0;
		if (is_act)
			addr[2:0] = row;  // row view
		else
		begin
			addr[16:14] = rcw;
			addr[10]    = ap;
			addr[2:0]   = col;
		end
		data_in = data;
		@(negedge ck_t);
		cs_n = 1'b1;
	end
	endtask

	task automatic wait_idle(input string name);
		int n;
	begin
		n = 0;
		while (busy && n < idle_limit)
		begin
			@(negedge ck_t);
			n++;
		end
		if (busy)
		begin
			errors++;
			$display("timeout in %s: device still busy after %0d cycles", name, idle_limit);
		end
	end
	endtask

	// the engine takes the command one edge after the pins are sampled
	task automatic settle(input string name);
	begin
		@(negedge ck_t);
		check({name, " busy"}, 16'h1, 16'(busy));
		wait_idle(name);
	end
	endtask

	task automatic wait_refresh(input string name, input int limit);
		int n;
	begin
		n = 0;
		while (!busy && n < limit)
		begin
			@(negedge ck_t);
			n++;
		end
		if (!busy)
		begin
			errors++;
			$display("timeout in %s: no periodic refresh within %0d cycles", name, limit);
		end
		else
			wait_idle(name);
	end
	endtask

	task automatic expect_read(input string name, input logic [15:0] word);
	begin
		exp_q.push_back(word);
		name_q.push_back(name);
		edge_q.push_back(cycle + 1);  // pins go out on the next rising edge
	end
	endtask

	// read returns, sampled mid-cycle
	always @(negedge ck_t)
	begin
		string       nm;
		logic [15:0] ev;
		int          issue_edge;
		if (rst_n && rd_valid)
		begin
			if (exp_q.size() == 0)
			begin
				errors++;
				$display("read data %h returned with no read outstanding", rd_data);
			end
			else
			begin
				nm         = name_q.pop_front();
				ev         = exp_q.pop_front();
				issue_edge = edge_q.pop_front();
				check(nm, ev, rd_data);
				// the coming rising edge is the one that sees this return
				check({nm, " latency"}, 16'(read_latency + 2), 16'(cycle + 1 - issue_edge));
			end
		end
	end

	initial
	begin
		int          i;
		int          n;
		logic        done;
		logic [15:0] op;
		logic [2:0]  bank;
		logic [2:0]  row;
		logic [2:0]  col;
		logic        ap;
		logic [15:0] d;
		logic [15:0] e;
		logic [31:0] rnd;
		string       name;
		seed    = 94;
		errors  = 0;
		checks  = 0;
		cycle   = 0;
		rst_n   = 1'b0;
		cs_n    = 1'b1;
		act_n   = 1'b1;
		bg      = 1'b0;
		ba      = 2'b00;
		addr    = '0;
		data_in = '0;
		$readmemh("tb/ddr_input.txt", stim);
		repeat (8) @(negedge ck_t);
		rst_n = 1'b1;
		@(negedge ck_t);
		check("reset busy", 16'h0, 16'(busy));
		check("reset rd_valid", 16'h0, 16'(rd_valid));

		i    = 0;
		done = 1'b0;
		while (!done && i < max_ops)
		begin
			op   = stim[i*fields];
			bank = {stim[i*fields+1][0], stim[i*fields+2][1:0]};
			row  = stim[i*fields+3][2:0];
			col  = stim[i*fields+4][2:0];
			ap   = stim[i*fields+5][0];
			d    = stim[i*fields+6];
			e    = stim[i*fields+7];
			name = $sformatf("op %0d", i);
			wait_idle(name);
			case (op)
				16'h1:
				begin
					issue(1'b1, 3'b000, bank, row, col, 1'b0, 16'h0);
					settle(name);
				end
				16'h2, 16'h7:
				begin
					if (op == 16'h7)
					begin
						rnd = $random(seed);
						d   = rnd[15:0];  // filler word
					end
					model[bank][row][col] = d;
					issue(1'b0, rcw_write, bank, row, col, ap, d);
					if (ap)
						settle(name);  // auto-precharge
				end
				16'h3, 16'h8, 16'h9:
				begin
					if (op == 16'h3)
						expect_read(name, e);
					else if (op == 16'h8)
						expect_read(name, model[bank][row][col]);
					issue(1'b0, rcw_read, bank, row, col, ap, 16'h0);  // 9 expects nothing
					if (ap)
						settle(name);
				end
				16'h4:
				begin
					issue(1'b0, rcw_precharge, bank, row, col, 1'b0, 16'h0);
					settle(name);
				end
				16'h5:
				begin
					issue(1'b0, rcw_refresh, bank, row, col, 1'b0, 16'h0);
					settle(name);
				end
				16'h6:
					wait_refresh(name, int'(d));
				default:
					done = 1'b1;  // end marker
			endcase
			i++;
		end

		n = 0;
		while (exp_q.size() != 0 && n < drain_limit)
		begin
			@(negedge ck_t);
			n++;
		end
		if (exp_q.size() != 0)
		begin
			errors++;
			$display("%0d reads never returned data", exp_q.size());
		end
		repeat (read_latency + 4) @(negedge ck_t);  // catch stray returns

		$display("checks: %0d  errors: %0d", checks, errors);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* tb/ddr_input.txt */
// op bg ba row col ap data expect, all hex
// op: 1 act 2 write 3 read 4 precharge 5 refresh 6 wait for periodic refresh (data = timeout)
// 7 random write 8 read of random word 9 read with no return 0 end
1 0 0 1 0 0 0000 0000
2 0 0 1 2 0 1234 0000
3 0 0 1 2 0 0000 1234
7 0 0 1 5 0 0000 0000
4 0 0 1 0 0 0000 0000
1 0 0 1 0 0 0000 0000
3 0 0 1 2 0 0000 1234
8 0 0 1 5 0 0000 0000
1 1 2 3 0 0 0000 0000
2 1 2 3 2 0 beef 0000
1 0 0 6 0 0 0000 0000
2 0 0 6 2 0 5a5a 0000
1 1 2 3 0 0 0000 0000
3 1 2 3 2 0 0000 beef
5 0 0 0 0 0 0000 0000
1 0 0 6 0 0 0000 0000
3 0 0 6 2 0 0000 5a5a
1 0 0 1 0 0 0000 0000
3 0 0 1 2 0 0000 1234
2 0 0 1 3 1 c3c3 0000
9 0 0 1 3 0 0000 0000
1 0 0 1 0 0 0000 0000
3 0 0 1 3 1 0000 c3c3
9 0 0 1 2 0 0000 0000
1 1 2 3 0 0 0000 0000
7 1 2 3 0 0 0000 0000
7 1 2 3 1 0 0000 0000
7 1 2 3 7 0 0000 0000
3 1 2 3 2 0 0000 beef
8 1 2 3 0 0 0000 0000
8 1 2 3 1 0 0000 0000
8 1 2 3 7 0 0000 0000
4 1 2 3 0 0 0000 0000
6 0 0 0 0 0 012c 0000
1 1 2 3 0 0 0000 0000
3 1 2 3 2 0 0000 beef
8 1 2 3 7 0 0000 0000
1 0 0 1 0 0 0000 0000
3 0 0 1 2 0 0000 1234
3 0 0 1 3 0 0000 c3c3
8 0 0 1 5 0 0000 0000
4 0 0 1 0 0 0000 0000
0 0 0 0 0 0 0000 0000

/* list.f */
hdl/ddr_geom_pkg.sv
hdl/ddr_cmd_pkg.sv
hdl/ddr_cmd_if.sv
hdl/cmd_decode.sv
hdl/refresh_timer.sv
hdl/bank_engine.sv
hdl/read_return.sv
hdl/ddr_bank_top.sv
tb/tb_ddr_bank.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_ddr_bank
FILELIST  = list.f
OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
PASS_MSG  = ALL TESTS PASSED

SOURCES = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
